/* dv/fft_power_assert.sv */
`default_nettype none

module fft_power_assert #(
    parameter int NFFT        = 16,
    parameter int POWER_WIDTH = 32
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       power_valid_i,
    input  wire logic [$clog2(NFFT)-1:0]    power_ptr_i,
    input  wire logic [POWER_WIDTH-1:0]     power_sample_i,
    input  wire logic                       fft_done_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int valid_run;    // valid cycles already seen in the current burst

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_run <= 0;
        end else if (power_valid_i) begin
            valid_run <= valid_run + 1;
        end else begin
            valid_run <= 0;
        end
    end

    done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        fft_done_i |=> !fft_done_i)
        else $error("fft_done_o stayed high for more than one cycle");

    valid_burst_length: assert property (@(posedge clk) disable iff (!rst_n)
        power_valid_i |-> (valid_run < NFFT/2))
        else $error("power_valid_o stayed high for more than NFFT/2 cycles");

    outputs_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({power_valid_i, power_ptr_i, power_sample_i, fft_done_i}))
        else $error("top-level output is unknown after reset");

endmodule

bind fft_power_top fft_power_assert #(
    .NFFT        (NFFT),
    .POWER_WIDTH (POWER_WIDTH)
) u_fft_power_assert (
    .clk            (clk),
    .rst_n          (rst_n),
    .power_valid_i  (power_valid_o),
    .power_ptr_i    (power_ptr_o),
    .power_sample_i (power_sample_o),
    .fft_done_i     (fft_done_o)
);

`default_nettype wire

/* dv/fft_power_tb.sv */
`default_nettype none

module fft_power_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NFFT        = 16;
    localparam int INPUT_WIDTH = 16;
    localparam int POWER_WIDTH = 32;
    localparam int PTR_W       = $clog2(NFFT);
    localparam int HALF        = NFFT / 2;
    localparam int LOAD_CYCLES = NFFT + 2;
    localparam int RUN_BUDGET  = PTR_W * (4 * HALF + NFFT + 4) + NFFT + 16;
    localparam int NUM_LOADS   = 7;
    localparam int NUM_RUNS    = 7;
    localparam int WATCHDOG_CYCLES =
        16 + NUM_LOADS * LOAD_CYCLES + NUM_RUNS * (RUN_BUDGET + 8) + 64;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    logic [PTR_W-1:0]       frame_ptr;
    logic [INPUT_WIDTH-1:0] real_in;
    logic                   start;
    logic                   power_valid;
    logic [PTR_W-1:0]       power_ptr;
    logic [POWER_WIDTH-1:0] power_sample;
    logic                   fft_done;

    logic [fft_pkg::TWIDDLE_WIDTH-1:0] twiddle_ref [HALF];
    logic [INPUT_WIDTH-1:0]            frame       [NFFT];    // natural order
    logic [POWER_WIDTH-1:0]            exp_power   [NFFT];    // only the first HALF used
    integer                            seed = 40819;
    int                                valid_cnt;
    int                                done_cnt;
    logic                              prev_valid;    // power_valid_o one cycle earlier

    fft_power_top #(
        .NFFT        (NFFT),
        .INPUT_WIDTH (INPUT_WIDTH),
        .POWER_WIDTH (POWER_WIDTH)
    ) UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid_i     (in_valid),
        .frame_ptr_i    (frame_ptr),
        .real_in_i      (real_in),
        .start_i        (start),
        .power_valid_o  (power_valid),
        .power_ptr_o    (power_ptr),
        .power_sample_o (power_sample),
        .fft_done_o     (fft_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_power(input string name, input logic [POWER_WIDTH-1:0] got,
                               input logic [POWER_WIDTH-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_ptr(input string name, input logic [PTR_W-1:0] got,
                             input logic [PTR_W-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            report_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // reference radix-2 FFT, same stage/group/butterfly order as the engine
    task automatic build_expected();
        fft_pkg::complex_t x [NFFT];
        fft_pkg::complex_t t;
        fft_pkg::complex_t u;
        logic [63:0]       pw;
        int                rev;
        int                half;
        int                step;
        for (int p = 0; p < NFFT; p++) begin
            rev = 0;
            for (int b = 0; b < PTR_W; b++) begin
                rev = (rev << 1) | ((p >> b) & 1);
            end
            x[rev].re = 32'(signed'(frame[p]));
            x[rev].im = '0;
        end
        for (int s = 1; s <= PTR_W; s++) begin
            half = 1 << (s - 1);
            step = NFFT >> s;
            for (int k = 0; k < NFFT; k += 2 * half) begin
                for (int j = 0; j < half; j++) begin
                    t = fft_pkg::c_mul(twiddle_ref[j * step], x[k + j + half]);
                    u = x[k + j];
                    x[k + j]        = fft_pkg::c_add(u, t);
                    x[k + j + half] = fft_pkg::c_sub(u, t);
                end
            end
        end
        for (int b = 0; b < HALF; b++) begin
            pw = fft_pkg::c_power(x[b]);
            exp_power[b] = pw[fft_pkg::POWER_LSB +: POWER_WIDTH];
        end
    endtask

    task automatic fill_random();
        for (int p = 0; p < NFFT; p++) begin
            frame[p] = INPUT_WIDTH'($random(seed));
        end
    endtask

    task automatic load_frame();
        for (int p = 0; p < NFFT; p++) begin
            @(negedge clk);
            in_valid  = 1'b1;
            frame_ptr = PTR_W'(p);
            real_in   = frame[p];
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic run_and_collect();
        int waited;
        valid_cnt = 0;
        done_cnt  = 0;
        waited    = 0;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (done_cnt == 0 && waited < RUN_BUDGET) begin
            @(posedge clk);
            waited++;
        end
        if (done_cnt == 0) begin
            report_failure("timeout while waiting for fft_done_o");
        end
        repeat (4) @(posedge clk);    // catch stray samples or pulses
        check_count("valid sample count", valid_cnt, HALF);
        check_count("fft_done_o pulse count", done_cnt, 1);
        @(negedge clk);
    endtask

    task automatic impulse_test();
        logic [63:0] pw;
        pw = 64'd1000 * 64'd1000;    // every twiddle product has a zero operand
        for (int p = 0; p < NFFT; p++) begin
            frame[p] = '0;
        end
        frame[0] = INPUT_WIDTH'(1000);
        for (int b = 0; b < HALF; b++) begin
            exp_power[b] = pw[fft_pkg::POWER_LSB +: POWER_WIDTH];
        end
        load_frame();
        run_and_collect();
    endtask

    task automatic zero_frame_test();
        for (int p = 0; p < NFFT; p++) begin
            frame[p]     = '0;
            exp_power[p] = '0;
        end
        load_frame();
        run_and_collect();
    endtask

    task automatic random_frame_test();
        fill_random();
        build_expected();
        load_frame();
        run_and_collect();
    endtask

    task automatic busy_input_test();
        fill_random();
        build_expected();
        load_frame();
        fork
            run_and_collect();
            begin
                repeat (3) @(negedge clk);
                for (int p = 0; p < NFFT; p++) begin
                    @(negedge clk);
                    in_valid  = 1'b1;
                    frame_ptr = PTR_W'(p);
                    real_in   = INPUT_WIDTH'(16'h7ff0 + p);    // must never reach the buffer
                end
                @(negedge clk);
                in_valid = 1'b0;
                start    = 1'b1;    // second start while busy
                @(negedge clk);
                start = 1'b0;
                wait (power_valid === 1'b1);
                @(negedge clk);
                in_valid  = 1'b1;    // spectrum still streaming out
                frame_ptr = PTR_W'(NFFT - 2);    // reversed address is the last bin
                real_in   = INPUT_WIDTH'(16'h7ff0);
                start     = 1'b1;
                @(negedge clk);
                in_valid = 1'b0;
                start    = 1'b0;
            end
        join
        random_frame_test();
    endtask

    task automatic back_to_back_test();
        for (int f = 0; f < 2; f++) begin
            fill_random();
            build_expected();
            load_frame();
            run_and_collect();
        end
    endtask

    // outputs settle after posedge, so look at them on the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (power_valid) begin
                if (valid_cnt != 0 && !prev_valid) begin
                    report_failure("power_valid_o dropped before the last bin was sent");
                end
                check_ptr("power_ptr_o", power_ptr, PTR_W'(valid_cnt));
                check_power("power_sample_o", power_sample, exp_power[power_ptr]);
                valid_cnt++;
            end
            if (fft_done) begin
                if (power_valid || !prev_valid) begin
                    report_failure("fft_done_o did not come one cycle after the last sample");
                end
                check_count("samples before fft_done_o", valid_cnt, HALF);
                done_cnt++;
            end
        end
        prev_valid = power_valid;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure("watchdog expired before the tests finished");
    end

    initial begin
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        frame_ptr  = '0;
        real_in    = '0;
        start      = 1'b0;
        valid_cnt  = 0;
        done_cnt   = 0;
        prev_valid = 1'b0;
        for (int b = 0; b < NFFT; b++) begin
            exp_power[b] = '0;
        end
        $readmemh("twiddles.hex", twiddle_ref);
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        impulse_test();
        zero_frame_test();
        random_frame_test();
        busy_input_test();
        back_to_back_test();

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/butterfly_engine.sv */
`default_nettype none

module butterfly_engine #(
    parameter int NFFT = 16
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       start_i,
    input  wire logic                       hold_i,

    output logic [$clog2(NFFT)-1:0]         rd_even_addr_o,
    output logic [$clog2(NFFT)-1:0]         rd_odd_addr_o,
    input  fft_pkg::complex_t               rd_even_i,
    input  fft_pkg::complex_t               rd_odd_i,

    output logic                            wr_en_o,
    output logic [$clog2(NFFT)-1:0]         wr_even_addr_o,
    output logic [$clog2(NFFT)-1:0]         wr_odd_addr_o,
    output fft_pkg::complex_t               wr_even_o,
    output fft_pkg::complex_t               wr_odd_o,

    output logic                            busy_o,
    output logic                            stages_done_o
);

    localparam int PTR_W  = $clog2(NFFT);
    localparam int CNT_W  = PTR_W + 1;    // room for k reaching NFFT
    localparam int TW_W   = $clog2(NFFT/2);
    localparam int LOG2_N = PTR_W;

    logic [fft_pkg::TWIDDLE_WIDTH-1:0] twiddle_rom [NFFT/2];

    initial begin
        $readmemh("twiddles.hex", twiddle_rom);
    end

    fft_pkg::fft_state_t state;

    logic [CNT_W-1:0] stage;
    logic [CNT_W-1:0] k_cnt;
    logic [CNT_W-1:0] j_cnt;
    logic [CNT_W-1:0] half_m;
    logic [CNT_W-1:0] tw_step;
    logic [TW_W-1:0]  tw_idx;
    logic [CNT_W-1:0] even_addr;
    logic [CNT_W-1:0] odd_addr;

    fft_pkg::complex_t t_q;    // twiddled odd operand
    fft_pkg::complex_t u_q;    // even operand

    assign even_addr = k_cnt + j_cnt;
    assign odd_addr  = k_cnt + j_cnt + half_m;

    assign rd_even_addr_o = even_addr[PTR_W-1:0];
    assign rd_odd_addr_o  = odd_addr[PTR_W-1:0];
    assign wr_even_addr_o = even_addr[PTR_W-1:0];
    assign wr_odd_addr_o  = odd_addr[PTR_W-1:0];

    assign wr_en_o   = (state == fft_pkg::UPDATE_VALUES);
    assign wr_even_o = fft_pkg::c_add(u_q, t_q);
    assign wr_odd_o  = fft_pkg::c_sub(u_q, t_q);

    assign busy_o        = (state != fft_pkg::IDLE);
    assign stages_done_o = (state == fft_pkg::FINISH);

    always_ff @(posedge clk) begin
        if (state == fft_pkg::BUTTERFLY_CALC) begin
            t_q <= fft_pkg::c_mul(twiddle_rom[tw_idx], rd_odd_i);
            u_q <= rd_even_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= fft_pkg::IDLE;
            stage   <= '0;
            k_cnt   <= '0;
            j_cnt   <= '0;
            half_m  <= '0;
            tw_step <= '0;
            tw_idx  <= '0;
        end else begin
            case (state)
                fft_pkg::IDLE: begin
                    stage <= CNT_W'(1);
                    if (start_i && !hold_i) begin
                        state <= fft_pkg::STAGE_INIT;
                    end
                end
                fft_pkg::STAGE_INIT: begin
                    half_m  <= CNT_W'(1) << (stage - 1'b1);
                    tw_step <= CNT_W'(NFFT) >> stage;
                    k_cnt   <= '0;
                    j_cnt   <= '0;
                    tw_idx  <= '0;
                    state   <= fft_pkg::BUTTERFLY_CALC;
                end
                fft_pkg::BUTTERFLY_CALC: begin
                    state <= fft_pkg::UPDATE_VALUES;
                end
                fft_pkg::UPDATE_VALUES: begin
                    state <= fft_pkg::NEXT_J;
                end
                fft_pkg::NEXT_J: begin
                    if (j_cnt < half_m - 1'b1) begin
                        j_cnt  <= j_cnt + 1'b1;
                        tw_idx <= tw_idx + tw_step[TW_W-1:0];
                        state  <= fft_pkg::BUTTERFLY_CALC;
                    end else begin
                        j_cnt  <= '0;
                        tw_idx <= '0;
                        k_cnt  <= k_cnt + (half_m << 1);    // next group, stride m
                        state  <= fft_pkg::NEXT_K;
                    end
                end
                fft_pkg::NEXT_K: begin
                    if (k_cnt < CNT_W'(NFFT)) begin
                        state <= fft_pkg::BUTTERFLY_CALC;
                    end else begin
                        k_cnt <= '0;
                        stage <= stage + 1'b1;
                        state <= fft_pkg::NEXT_STAGE;
                    end
                end
                fft_pkg::NEXT_STAGE: begin
                    if (stage <= CNT_W'(LOG2_N)) begin
                        state <= fft_pkg::STAGE_INIT;
                    end else begin
                        state <= fft_pkg::FINISH;
                    end
                end
                fft_pkg::FINISH: begin
                    state <= fft_pkg::IDLE;
                end
                default: begin
                    state <= fft_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/fft_pkg.sv */
`default_nettype none

package fft_pkg;

    localparam int CWIDTH        = 32;
    localparam int TWIDDLE_WIDTH = 32;    // q1.15 real in upper half, imag in lower half
    localparam int POWER_LSB     = 9;

    typedef struct packed {
        logic signed [CWIDTH-1:0] re;
        logic signed [CWIDTH-1:0] im;
    } complex_t;

    typedef enum logic [3:0] {
        IDLE,
        STAGE_INIT,
        BUTTERFLY_CALC,
        UPDATE_VALUES,
        NEXT_J,
        NEXT_K,
        NEXT_STAGE,
        FINISH
    } fft_state_t;

    function automatic complex_t c_mul(input logic [TWIDDLE_WIDTH-1:0] w, input complex_t x);
        logic signed [15:0] w_re;
        logic signed [15:0] w_im;
        logic signed [63:0] p_rr;
        logic signed [63:0] p_ii;
        logic signed [63:0] p_ri;
        logic signed [63:0] p_ir;
        logic signed [63:0] sum_re;
        logic signed [63:0] sum_im;
        complex_t           res;
        w_re   = w[TWIDDLE_WIDTH-1:16];
        w_im   = w[15:0];
        p_rr   = (w_re * x.re) >>> 15;    // each partial truncated on its own
        p_ii   = (w_im * x.im) >>> 15;
        p_ri   = (w_re * x.im) >>> 15;
        p_ir   = (w_im * x.re) >>> 15;
        sum_re = p_rr - p_ii;
        sum_im = p_ri + p_ir;
        res.re = sum_re[CWIDTH-1:0];
        res.im = sum_im[CWIDTH-1:0];
        return res;
    endfunction

    function automatic complex_t c_add(input complex_t a, input complex_t b);
        complex_t res;
        res.re = a.re + b.re;
        res.im = a.im + b.im;
        return res;
    endfunction

    function automatic complex_t c_sub(input complex_t a, input complex_t b);
        complex_t res;
        res.re = a.re - b.re;
        res.im = a.im - b.im;
        return res;
    endfunction

    function automatic logic [63:0] c_power(input complex_t a);
        logic signed [63:0] sq_re;
        logic signed [63:0] sq_im;
        sq_re = a.re * a.re;
        sq_im = a.im * a.im;
        return 64'(sq_re) + 64'(sq_im);
    endfunction

endpackage

`default_nettype wire

/* logic/fft_power_top.sv */
`default_nettype none

module fft_power_top #(
    parameter int NFFT        = 16,
    parameter int INPUT_WIDTH = 16,
    parameter int POWER_WIDTH = 32
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,

    input  wire logic                       in_valid_i,
    input  wire logic [$clog2(NFFT)-1:0]    frame_ptr_i,
    input  wire logic [INPUT_WIDTH-1:0]     real_in_i,
    input  wire logic                       start_i,

    output logic                            power_valid_o,
    output logic [$clog2(NFFT)-1:0]         power_ptr_o,
    output logic [POWER_WIDTH-1:0]          power_sample_o,
    output logic                            fft_done_o
);

    localparam int PTR_W = $clog2(NFFT);

    logic [PTR_W-1:0]  rd_even_addr;
    logic [PTR_W-1:0]  rd_odd_addr;
    fft_pkg::complex_t rd_even;
    fft_pkg::complex_t rd_odd;
    logic              wr_en;
    logic [PTR_W-1:0]  wr_even_addr;
    logic [PTR_W-1:0]  wr_odd_addr;
    fft_pkg::complex_t wr_even;
    fft_pkg::complex_t wr_odd;
    logic [PTR_W-1:0]  out_addr;
    fft_pkg::complex_t out_data;
    logic              eng_busy;
    logic              pwr_busy;
    logic              busy_all;
    logic              stages_done;

    assign busy_all = eng_busy | pwr_busy;    // input and start locked until spectrum is out

    frame_buffer #(
        .NFFT        (NFFT),
        .INPUT_WIDTH (INPUT_WIDTH)
    ) u_frame_buffer (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid_i     (in_valid_i),
        .frame_ptr_i    (frame_ptr_i),
        .real_in_i      (real_in_i),
        .busy_i         (busy_all),
        .rd_even_addr_i (rd_even_addr),
        .rd_odd_addr_i  (rd_odd_addr),
        .rd_even_o      (rd_even),
        .rd_odd_o       (rd_odd),
        .wr_en_i        (wr_en),
        .wr_even_addr_i (wr_even_addr),
        .wr_odd_addr_i  (wr_odd_addr),
        .wr_even_i      (wr_even),
        .wr_odd_i       (wr_odd),
        .out_addr_i     (out_addr),
        .out_data_o     (out_data)
    );

    butterfly_engine #(
        .NFFT (NFFT)
    ) u_butterfly_engine (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_i),
        .hold_i         (busy_all),
        .rd_even_addr_o (rd_even_addr),
        .rd_odd_addr_o  (rd_odd_addr),
        .rd_even_i      (rd_even),
        .rd_odd_i       (rd_odd),
        .wr_en_o        (wr_en),
        .wr_even_addr_o (wr_even_addr),
        .wr_odd_addr_o  (wr_odd_addr),
        .wr_even_o      (wr_even),
        .wr_odd_o       (wr_odd),
        .busy_o         (eng_busy),
        .stages_done_o  (stages_done)
    );

    power_stream #(
        .NFFT        (NFFT),
        .POWER_WIDTH (POWER_WIDTH)
    ) u_power_stream (
        .clk            (clk),
        .rst_n          (rst_n),
        .stages_done_i  (stages_done),
        .out_addr_o     (out_addr),
        .out_data_i     (out_data),
        .busy_o         (pwr_busy),
        .power_valid_o  (power_valid_o),
        .power_ptr_o    (power_ptr_o),
        .power_sample_o (power_sample_o),
        .fft_done_o     (fft_done_o)
    );

endmodule

`default_nettype wire

/* logic/frame_buffer.sv */
`default_nettype none

module frame_buffer #(
    parameter int NFFT        = 16,
    parameter int INPUT_WIDTH = 16
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,

    input  wire logic                       in_valid_i,
    input  wire logic [$clog2(NFFT)-1:0]    frame_ptr_i,
    input  wire logic [INPUT_WIDTH-1:0]     real_in_i,
    input  wire logic                       busy_i,

    input  wire logic [$clog2(NFFT)-1:0]    rd_even_addr_i,
    input  wire logic [$clog2(NFFT)-1:0]    rd_odd_addr_i,
    output fft_pkg::complex_t               rd_even_o,
    output fft_pkg::complex_t               rd_odd_o,

    input  wire logic                       wr_en_i,
    input  wire logic [$clog2(NFFT)-1:0]    wr_even_addr_i,
    input  wire logic [$clog2(NFFT)-1:0]    wr_odd_addr_i,
    input  fft_pkg::complex_t               wr_even_i,
    input  fft_pkg::complex_t               wr_odd_i,

    input  wire logic [$clog2(NFFT)-1:0]    out_addr_i,
    output fft_pkg::complex_t               out_data_o
);

    localparam int PTR_W = $clog2(NFFT);

    fft_pkg::complex_t mem [NFFT];

    logic [PTR_W-1:0] ptr_rev;

    always_comb begin
        for (int b = 0; b < PTR_W; b++) begin
            ptr_rev[b] = frame_ptr_i[PTR_W-1-b];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NFFT; i++) begin
                mem[i] <= '0;
            end
        end else if (in_valid_i && !busy_i) begin    // samples offered while busy are lost
            mem[ptr_rev].re <= {{(fft_pkg::CWIDTH-INPUT_WIDTH){real_in_i[INPUT_WIDTH-1]}},
                                real_in_i};
            mem[ptr_rev].im <= '0;
        end else if (wr_en_i) begin
            mem[wr_even_addr_i] <= wr_even_i;
            mem[wr_odd_addr_i]  <= wr_odd_i;
        end
    end

    assign rd_even_o  = mem[rd_even_addr_i];
    assign rd_odd_o   = mem[rd_odd_addr_i];
    assign out_data_o = mem[out_addr_i];

endmodule

`default_nettype wire

/* logic/power_stream.sv */
`default_nettype none

module power_stream #(
    parameter int NFFT        = 16,
    parameter int POWER_WIDTH = 32
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       stages_done_i,

    output logic [$clog2(NFFT)-1:0]         out_addr_o,
    input  fft_pkg::complex_t               out_data_i,

    output logic                            busy_o,
    output logic                            power_valid_o,
    output logic [$clog2(NFFT)-1:0]         power_ptr_o,
    output logic [POWER_WIDTH-1:0]          power_sample_o,
    output logic                            fft_done_o
);

    localparam int PTR_W = $clog2(NFFT);
    localparam logic [PTR_W-1:0] LAST_BIN = PTR_W'(NFFT/2 - 1);

    logic [PTR_W-1:0] bin_cnt;
    logic             run;
    logic [63:0]      power_full;

    assign out_addr_o = bin_cnt;
    assign power_full = fft_pkg::c_power(out_data_i);
    assign busy_o     = run || power_valid_o;    // covers the last sample too

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bin_cnt        <= '0;
            run            <= 1'b0;
            power_valid_o  <= 1'b0;
            power_ptr_o    <= '0;
            power_sample_o <= '0;
            fft_done_o     <= 1'b0;
        end else begin
            power_valid_o <= 1'b0;
            fft_done_o    <= power_valid_o && !run;    // one cycle after the last bin
            if (stages_done_i || run) begin
                power_valid_o  <= 1'b1;
                power_ptr_o    <= bin_cnt;
                power_sample_o <= power_full[fft_pkg::POWER_LSB +: POWER_WIDTH];
                if (bin_cnt == LAST_BIN) begin
                    run     <= 1'b0;
                    bin_cnt <= '0;
                end else begin
                    run     <= 1'b1;
                    bin_cnt <= bin_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module fft_power_tb -o sim_fft_power

./obj_dir/sim_fft_power > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "simulation ended without the pass line"
    exit 1
fi
echo "simulation passed"

/* twiddles.hex */
// W^k = exp(-j*2*pi*k/16) in Q1.15, one word per k = 0..7, re in [31:16], im in [15:0]
7FFF0000
7642CF04
5A82A57E
30FC89BE
00008000
CF0489BE
A57EA57E
89BECF04

/* verilog.f */
logic/fft_pkg.sv
logic/frame_buffer.sv
logic/butterfly_engine.sv
logic/power_stream.sv
logic/fft_power_top.sv
dv/fft_power_assert.sv
dv/fft_power_tb.sv
